// File: design/midi_pkg.sv
package midi_pkg;

    // one byte on the MIDI wire
    typedef logic [7:0] midi_byte_t;

    // received byte together with the count it produces
    typedef struct packed {
        midi_byte_t data;
        logic [7:0] count;
    } midi_rx_word_t;

    // running status and data bytes seen since it
    typedef struct packed {
        midi_byte_t status;
        logic [7:0] data_count;
    } midi_status_t;

    // bit 7 marks a status byte
    localparam midi_byte_t STATUS_MASK = 8'h80;

    // end of sysex, counted as data
    localparam midi_byte_t SYSEX_END = 8'hf7;

    // start, 8 data, stop
    localparam int FRAME_BITS = 10;

endpackage

// File: design/midi_bit_timer.sv
`timescale 1ns/1ns

module midi_bit_timer #(
    parameter int CLKS_PER_BIT = 1600
) (
    input  logic data_clk,
    input  logic reset_reg_N,
    input  logic restart,
    input  logic run,
    output logic mid_tick,
    output logic bit_tick
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] MID_CNT = CNT_W'(CLKS_PER_BIT / 2 - 1);

    // position inside the current bit
    logic [CNT_W-1:0] phase_cnt;

    always_ff @(posedge data_clk or negedge reset_reg_N) begin
        if (!reset_reg_N) begin
            phase_cnt <= '0;
        end else if (restart) begin
            phase_cnt <= '0;
        end else if (run) begin
            if (phase_cnt == LAST_CNT) begin
                phase_cnt <= '0;
            end else begin
                phase_cnt <= phase_cnt + 1'b1;
            end
        end
    end

    // half a bit after the bit start
    assign mid_tick = run && !restart && (phase_cnt == MID_CNT);

    // last cycle of the bit
    assign bit_tick = run && !restart && (phase_cnt == LAST_CNT);

endmodule

// File: design/midi_rx.sv
`timescale 1ns/1ns

module midi_rx #(
    parameter int CLKS_PER_BIT = 1600
) (
    input  logic                 data_clk,
    input  logic                 reset_reg_N,
    input  logic                 midi_rxd,
    output midi_pkg::midi_byte_t rx_byte,
    output logic                 rx_valid
);

    localparam int IDX_W = $clog2(midi_pkg::FRAME_BITS);
    localparam logic [IDX_W-1:0] STOP_IDX = IDX_W'(midi_pkg::FRAME_BITS - 1);

    // two samples of the raw line
    logic [1:0] rxd_sync;
    logic       line_ok;
    // filtered line, idles high
    logic       rx_line;

    logic                 busy;
    logic                 start_seen;
    logic [IDX_W-1:0]     bit_idx;
    midi_pkg::midi_byte_t shift_reg;
    logic                 mid_tick;

    // low only when three samples in a row are low
    assign line_ok = midi_rxd | rxd_sync[0] | rxd_sync[1];

    always_ff @(posedge data_clk or negedge reset_reg_N) begin
        if (!reset_reg_N) begin
            rxd_sync <= 2'b11;
            rx_line  <= 1'b1;
        end else begin
            rxd_sync <= {rxd_sync[0], midi_rxd};
            rx_line  <= line_ok;
        end
    end

    // falling edge while idle starts a frame
    assign start_seen = !busy && !rx_line;

    midi_bit_timer #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_rx_timer (
        .data_clk   (data_clk),
        .reset_reg_N(reset_reg_N),
        .restart    (start_seen),
        .run        (busy),
        .mid_tick   (mid_tick),
        .bit_tick   ()
    );

    always_ff @(posedge data_clk or negedge reset_reg_N) begin
        if (!reset_reg_N) begin
            busy     <= 1'b0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
            rx_byte  <= '0;
        end else begin
            rx_valid <= 1'b0;
            if (start_seen) begin
                busy    <= 1'b1;
                bit_idx <= '0;
            end else if (busy && mid_tick) begin
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == '0) begin
                    // start bit gone by mid-bit, just a glitch
                    if (rx_line) begin
                        busy <= 1'b0;
                    end
                end else if (bit_idx == STOP_IDX) begin
                    busy <= 1'b0;
                    // low stop bit drops the frame
                    if (rx_line) begin
                        rx_valid <= 1'b1;
                        rx_byte  <= shift_reg;
                    end
                end
            end
        end
    end

    // data bits arrive LSB first
    always_ff @(posedge data_clk) begin
        if (busy && mid_tick && (bit_idx != '0) && (bit_idx != STOP_IDX)) begin
            shift_reg <= {rx_line, shift_reg[7:1]};
        end
    end

endmodule

// File: design/midi_status_tracker.sv
`timescale 1ns/1ns

module midi_status_tracker (
    input  logic                   data_clk,
    input  logic                   reset_reg_N,
    input  midi_pkg::midi_byte_t   rx_byte,
    input  logic                   rx_valid,
    output midi_pkg::midi_status_t cur_status
);

    // incoming byte and the count it would give as data
    midi_pkg::midi_rx_word_t rx_word;
    logic                    is_status;

    assign rx_word = '{
        data:  rx_byte,
        count: cur_status.data_count + 8'd1
    };

    // F7 closes sysex but does not replace the running status
    assign is_status = ((rx_word.data & midi_pkg::STATUS_MASK) != '0) &&
                       (rx_word.data != midi_pkg::SYSEX_END);

    always_ff @(posedge data_clk or negedge reset_reg_N) begin
        if (!reset_reg_N) begin
            cur_status <= '0;
        end else if (rx_valid) begin
            if (is_status) begin
                cur_status.status     <= rx_word.data;
                cur_status.data_count <= '0;
            end else begin
                // wraps at 256
                cur_status.data_count <= rx_word.count;
            end
        end
    end

endmodule

// File: design/midi_tx.sv
`timescale 1ns/1ns

module midi_tx #(
    parameter int CLKS_PER_BIT = 1600
) (
    input  logic                 data_clk,
    input  logic                 reset_reg_N,
    input  logic                 send_byte,
    input  midi_pkg::midi_byte_t out_data,
    output logic                 midi_txd,
    output logic                 out_ready
);

    localparam int IDX_W = $clog2(midi_pkg::FRAME_BITS);
    localparam logic [IDX_W-1:0] STOP_IDX = IDX_W'(midi_pkg::FRAME_BITS - 2);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(midi_pkg::FRAME_BITS - 1);

    logic                 accept;
    logic                 bit_tick;
    // bit currently on the line, 0 is the start bit
    logic [IDX_W-1:0]     bit_idx;
    midi_pkg::midi_byte_t shift_reg;

    // sends while busy are dropped
    assign accept = send_byte && out_ready;

    midi_bit_timer #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_tx_timer (
        .data_clk   (data_clk),
        .reset_reg_N(reset_reg_N),
        .restart    (accept),
        .run        (!out_ready),
        .mid_tick   (),
        .bit_tick   (bit_tick)
    );

    always_ff @(posedge data_clk or negedge reset_reg_N) begin
        if (!reset_reg_N) begin
            out_ready <= 1'b1;
            midi_txd  <= 1'b1;
            bit_idx   <= '0;
        end else if (accept) begin
            out_ready <= 1'b0;
            midi_txd  <= 1'b0;
            bit_idx   <= '0;
        end else if (!out_ready && bit_tick) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == LAST_IDX) begin
                // stop bit done, line stays idle high
                out_ready <= 1'b1;
                bit_idx   <= '0;
            end else if (bit_idx == STOP_IDX) begin
                midi_txd <= 1'b1;
            end else begin
                midi_txd <= shift_reg[0];
            end
        end
    end

    // byte latched on accept, shifted out LSB first
    always_ff @(posedge data_clk) begin
        if (accept) begin
            shift_reg <= out_data;
        end else if (!out_ready && bit_tick) begin
            shift_reg <= shift_reg >> 1;
        end
    end

endmodule

// File: design/midi_port.sv
`timescale 1ns/1ns

module midi_port #(
    parameter int CLKS_PER_BIT = 1600
) (
    input  logic                   data_clk,
    input  logic                   reset_reg_N,
    // receive side
    input  logic                   midi_rxd,
    output logic                   byte_ready,
    output midi_pkg::midi_byte_t   midi_in_data,
    output midi_pkg::midi_status_t cur_status,
    // transmit side
    input  logic                   send_byte,
    input  midi_pkg::midi_byte_t   out_data,
    output logic                   midi_txd,
    output logic                   out_ready
);

    // received bytes go out and into the tracker
    midi_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_rx (
        .data_clk   (data_clk),
        .reset_reg_N(reset_reg_N),
        .midi_rxd   (midi_rxd),
        .rx_byte    (midi_in_data),
        .rx_valid   (byte_ready)
    );

    midi_status_tracker u_tracker (
        .data_clk   (data_clk),
        .reset_reg_N(reset_reg_N),
        .rx_byte    (midi_in_data),
        .rx_valid   (byte_ready),
        .cur_status (cur_status)
    );

    // independent of the receiver timing
    midi_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_tx (
        .data_clk   (data_clk),
        .reset_reg_N(reset_reg_N),
        .send_byte  (send_byte),
        .out_data   (out_data),
        .midi_txd   (midi_txd),
        .out_ready  (out_ready)
    );

endmodule

// File: tests/midi_clk_gen.sv
`timescale 1ns/1ns

module midi_clk_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic data_clk,
    output logic reset_reg_N
);

    initial begin
        data_clk = 1'b0;
        forever #(PERIOD_NS / 2) data_clk = ~data_clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        reset_reg_N = 1'b0;
        repeat (RESET_CYCLES) @(posedge data_clk);
        @(negedge data_clk);
        reset_reg_N = 1'b1;
    end

endmodule

// File: tests/midi_port_chk.sv
`timescale 1ns/1ns

module midi_port_chk #(
    parameter int CLKS_PER_BIT = 16
) (
    input logic                   data_clk,
    input logic                   reset_reg_N,
    input logic                   byte_ready,
    input midi_pkg::midi_byte_t   midi_in_data,
    input midi_pkg::midi_status_t cur_status,
    input logic                   send_byte,
    input midi_pkg::midi_byte_t   out_data,
    input logic                   midi_txd,
    input logic                   out_ready
);

    localparam int FRAME_CYCLES = midi_pkg::FRAME_BITS * CLKS_PER_BIT;

    logic       failed = 1'b0;
    logic       first_cycle;
    logic       accept;
    logic       pending;
    logic [7:0] last_sent;
    logic       ready_d;
    logic [7:0] model_status;
    logic [7:0] model_count;
    // cycle number inside the current transmit frame or 0 when idle
    int         tx_win;

    assign accept = send_byte && out_ready;

    always_ff @(posedge data_clk or negedge reset_reg_N) begin
        if (!reset_reg_N) begin
            first_cycle  <= 1'b1;
            pending      <= 1'b0;
            last_sent    <= '0;
            ready_d      <= 1'b0;
            model_status <= '0;
            model_count  <= '0;
            tx_win       <= 0;
        end else begin
            first_cycle <= 1'b0;
            ready_d     <= byte_ready;
            if (accept) begin
                pending   <= 1'b1;
                last_sent <= out_data;
            end else if (byte_ready) begin
                pending <= 1'b0;
            end
            // F7 counts as data under the running status rule
            if (byte_ready) begin
                if (midi_in_data[7] && midi_in_data != 8'hf7) begin
                    model_status <= midi_in_data;
                    model_count  <= '0;
                end else begin
                    model_count <= model_count + 8'd1;
                end
            end
            if (accept) begin
                tx_win <= 1;
            end else if (tx_win != 0 && tx_win <= FRAME_CYCLES) begin
                tx_win <= tx_win + 1;
            end else begin
                tx_win <= 0;
            end
        end
    end

    a_reset_state: assert property (@(posedge data_clk)
        first_cycle |-> out_ready && midi_txd && !byte_ready)
        else begin failed = 1'b1; $error("outputs wrong right after reset"); end

    a_rx_data: assert property (@(posedge data_clk) disable iff (!reset_reg_N)
        byte_ready |-> pending && midi_in_data == last_sent)
        else begin failed = 1'b1; $error("unexpected or wrong received byte"); end

    a_one_frame: assert property (@(posedge data_clk) disable iff (!reset_reg_N)
        accept |-> !pending || byte_ready)
        else begin failed = 1'b1; $error("sent byte never came back"); end

    a_busy: assert property (@(posedge data_clk) disable iff (!reset_reg_N)
        (tx_win != 0 && tx_win <= FRAME_CYCLES) |-> !out_ready)
        else begin failed = 1'b1; $error("out_ready high inside a frame"); end

    a_start_bit: assert property (@(posedge data_clk) disable iff (!reset_reg_N)
        (tx_win != 0 && tx_win <= CLKS_PER_BIT) |-> !midi_txd)
        else begin failed = 1'b1; $error("start bit not low"); end

    a_stop_bit: assert property (@(posedge data_clk) disable iff (!reset_reg_N)
        (tx_win > FRAME_CYCLES - CLKS_PER_BIT && tx_win <= FRAME_CYCLES) |-> midi_txd)
        else begin failed = 1'b1; $error("stop bit not high"); end

    a_ready_back: assert property (@(posedge data_clk) disable iff (!reset_reg_N)
        (tx_win == FRAME_CYCLES + 1) |-> out_ready)
        else begin failed = 1'b1; $error("out_ready late after frame"); end

    a_status: assert property (@(posedge data_clk) disable iff (!reset_reg_N)
        ready_d |-> cur_status == {model_status, model_count})
        else begin failed = 1'b1; $error("running status mismatch"); end

endmodule

// File: tests/midi_tb.sv
`timescale 1ns/1ns

module midi_tb;

    localparam int CPB         = 16;
    localparam int PERIOD_NS   = 4;
    localparam int NUM_RANDOM  = 200;
    localparam int NUM_FRAMES  = NUM_RANDOM + 6;
    localparam int TIMEOUT_NS  = NUM_FRAMES * midi_pkg::FRAME_BITS * CPB * PERIOD_NS + 20000;
    localparam logic [31:0] SEED = 32'h79eb_5965;

    logic                   data_clk;
    logic                   reset_reg_N;
    logic                   midi_rxd;
    logic                   byte_ready;
    midi_pkg::midi_byte_t   midi_in_data;
    midi_pkg::midi_status_t cur_status;
    logic                   send_byte;
    midi_pkg::midi_byte_t   out_data;
    logic                   midi_txd;
    logic                   out_ready;
    logic                   use_loop;
    logic                   serial_line;
    logic [31:0]            lfsr_state;

    midi_clk_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(10)) u_clk (
        .data_clk   (data_clk),
        .reset_reg_N(reset_reg_N)
    );

    // loopback or a line driven by the testbench
    assign midi_rxd = use_loop ? midi_txd : serial_line;

    midi_port #(.CLKS_PER_BIT(CPB)) DUT (
        .data_clk    (data_clk),
        .reset_reg_N (reset_reg_N),
        .midi_rxd    (midi_rxd),
        .byte_ready  (byte_ready),
        .midi_in_data(midi_in_data),
        .cur_status  (cur_status),
        .send_byte   (send_byte),
        .out_data    (out_data),
        .midi_txd    (midi_txd),
        .out_ready   (out_ready)
    );

    bind midi_port midi_port_chk #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_chk (
        .data_clk(data_clk), .reset_reg_N(reset_reg_N), .byte_ready(byte_ready),
        .midi_in_data(midi_in_data), .cur_status(cur_status),
        .send_byte(send_byte), .out_data(out_data), .midi_txd(midi_txd),
        .out_ready(out_ready)
    );

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_byte(output midi_pkg::midi_byte_t value);
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value[i] = lfsr_state[0];
        end
    endtask

    // send when ready, then poke a send while busy
    task automatic send_one(input midi_pkg::midi_byte_t value);
        @(negedge data_clk);
        while (!out_ready) @(negedge data_clk);
        send_byte = 1'b1;
        out_data  = value;
        @(negedge data_clk);
        send_byte = 1'b0;
        repeat (3 * CPB) @(negedge data_clk);
        send_byte = 1'b1;
        out_data  = ~value;
        @(negedge data_clk);
        send_byte = 1'b0;
    endtask

    task automatic drive_frame(input midi_pkg::midi_byte_t value, input logic stop_val);
        serial_line = 1'b0;
        repeat (CPB) @(negedge data_clk);
        for (int i = 0; i < 8; i++) begin
            serial_line = value[i];
            repeat (CPB) @(negedge data_clk);
        end
        serial_line = stop_val;
        repeat (CPB) @(negedge data_clk);
        serial_line = 1'b1;
        repeat (2 * CPB) @(negedge data_clk);
    endtask

    task automatic wait_byte_ready();
        do @(negedge data_clk); while (!byte_ready);
    endtask

    always @(negedge data_clk) begin
        if (DUT.u_chk.failed) begin
            $display("Fail at %0t ns: port checker assertion failed", $time);
            $display("Test FAILED");
            $fatal(1, "stopping on first error");
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timed out: the tests did not finish in the expected time");
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        midi_pkg::midi_byte_t value;
        send_byte   = 1'b0;
        out_data    = '0;
        use_loop    = 1'b1;
        serial_line = 1'b1;
        lfsr_state  = SEED;
        wait (reset_reg_N);
        repeat (4) @(negedge data_clk);

        // fixed running status cases first
        send_one(8'h90);
        send_one(8'h3c);
        send_one(8'hf7);
        send_one(8'h40);
        for (int n = 0; n < NUM_RANDOM; n++) begin
            take_byte(value);
            send_one(value);
        end
        while (!out_ready) @(negedge data_clk);
        repeat (4 * CPB) @(negedge data_clk);

        // frame with a low stop bit, then a good one
        use_loop = 1'b0;
        take_byte(value);
        drive_frame(value, 1'b0);
        take_byte(value);
        fork
            send_one(value);
            drive_frame(value, 1'b1);
            wait_byte_ready();
        join
        repeat (4 * CPB) @(negedge data_clk);

        if (DUT.u_chk.failed) begin
            $display("Fail at %0t ns: port checker assertion failed", $time);
            $display("Test FAILED");
            $fatal(1, "checker error at end of run");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

// File: project.f
design/midi_pkg.sv
design/midi_bit_timer.sv
design/midi_rx.sv
design/midi_status_tracker.sv
design/midi_tx.sv
design/midi_port.sv
tests/midi_clk_gen.sv
tests/midi_port_chk.sv
tests/midi_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the MIDI port testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --top-module midi_tb -f project.f \
    -o Vmidi_tb > build.log 2>&1 \
    && ./obj_dir/Vmidi_tb > sim.log 2>&1 \
    || echo "Test FAILED" >> sim.log

cat sim.log

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0
